//--- all.f
hw/fetch_pkg.sv
hw/fetch_stage_f1.sv
hw/fetch_itlb.sv
hw/fetch_imem.sv
hw/fetch_stage_f2.sv
hw/fetch_frontend.sv
tests/fetch_tb.sv

//--- build.sh
#!/usr/bin/env bash
# Compile the fetch front end testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        -f all.f --top-module fetch_tb -o fetch_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/fetch_sim 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Result: PASSED"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi

//--- tests/fetch_tb.sv
// Testbench for the fetch front end that plays the page walker and decode and checks the fetch stream
`default_nettype none
`timescale 1ns/100ps

module fetch_tb;

    import fetch_pkg::*;

    localparam int ITLB_INDEX_BITS = 3;
    localparam int IMEM_ADDR_BITS  = 10;
    localparam int IMEM_WORDS      = 2 ** IMEM_ADDR_BITS;
    localparam int PAGE_WORDS      = 2 ** PAGE_OFF_BITS;
    localparam int RESET_CYCLES    = 3;
    localparam logic [31:0] SEED   = 32'd34247;

    // Fetch starts at byte address 0x1000
    localparam pc_word_t FIRST_PC_WORD = pc_word_t'(32'h0000_1000 / 4);

    // Fetch counts per test phase
    localparam int RUNS            = 4;
    localparam int RUN_FETCHES     = 50;
    localparam int STALL_FETCHES   = 200;
    localparam int BRANCH_FETCHES  = 300;
    localparam int TOTAL_FETCHES   = 1 + RUNS * RUN_FETCHES + STALL_FETCHES + BRANCH_FETCHES;

    // Pages 1 to 8 land in distinct TLB entries
    localparam int MAX_PAGES       = 8;
    localparam int MAX_WALK_DELAY  = 8;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + IMEM_WORDS
                                     + 4 * (TOTAL_FETCHES + MAX_PAGES * MAX_WALK_DELAY);

    logic                      clk;
    logic                      rst_n;
    logic                      branch_taken;
    pc_word_t                  branch_target;
    logic                      miss_valid;
    vpn_t                      miss_vpn;
    logic                      fill_valid = 1'b0;
    vpn_t                      fill_vpn = '0;
    ppn_t                      fill_ppn = '0;
    logic                      load_en;
    logic [IMEM_ADDR_BITS-1:0] load_addr;
    word_t                     load_data;
    logic                      out_valid;
    pc_word_t                  out_pc_word;
    word_t                     out_instr;
    logic                      ready;

    // Walker model state
    logic        walker_on;
    logic        walk_busy = 1'b0;
    logic        walk_track = 1'b0;
    int          walk_count = 0;
    vpn_t        walk_vpn = '0;
    logic [31:0] walk_rng = SEED;
    bit          page_filled [vpn_t];

    // Checker state
    pc_word_t    expect_pc = FIRST_PC_WORD;
    int          accepted = 0;
    logic        held = 1'b0;
    pc_word_t    held_pc = '0;
    word_t       held_instr = '0;

    logic [31:0] stim_rng = SEED;
    int          cycles = 0;

    fetch_frontend #(
        .ITLB_INDEX_BITS (ITLB_INDEX_BITS),
        .IMEM_ADDR_BITS  (IMEM_ADDR_BITS)
    ) dut0 (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_miss_vpn      (miss_vpn),
        .o_miss_valid    (miss_valid),
        .i_fill_valid    (fill_valid),
        .i_fill_vpn      (fill_vpn),
        .i_fill_ppn      (fill_ppn),
        .i_load_en       (load_en),
        .i_load_addr     (load_addr),
        .i_load_data     (load_data),
        .o_valid         (out_valid),
        .o_pc_word       (out_pc_word),
        .o_instr         (out_instr),
        .i_ready         (ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Memory word holds its own address scrambled
    function automatic word_t load_pattern(input logic [IMEM_ADDR_BITS-1:0] addr);
        return word_t'(addr) ^ 32'h5A5A_5A5A;
    endfunction

    function automatic ppn_t map_ppn(input vpn_t vpn);
        return ppn_t'(vpn ^ vpn_t'(3));
    endfunction

    // Reference model of one fetch
    function automatic word_t expected_instr(input pc_word_t pc);
        vpn_t        vpn;
        paddr_word_t paddr;
        vpn   = pc[PC_WORD_BITS-1:PAGE_OFF_BITS];
        paddr = {map_ppn(vpn), pc[PAGE_OFF_BITS-1:0]};
        return load_pattern(paddr[IMEM_ADDR_BITS-1:0]);
    endfunction

    // Somewhere in pages 1 to 7
    function automatic pc_word_t random_target(input logic [31:0] rnd);
        return pc_word_t'(PAGE_WORDS + int'(rnd[31:16]) % ((MAX_PAGES - 1) * PAGE_WORDS));
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Pending walk keeps its request up until a redirect moves the PC
    task automatic check_miss_request();
        if (walk_track) begin
            assert (miss_valid && miss_vpn == walk_vpn) else
                stop_on_error($sformatf("mismatch at time %0t: miss request for page %h %s",
                                        $time, walk_vpn, "dropped or changed"));
        end
        if (branch_taken) begin
            walk_track = 1'b0;
        end
    endtask

    task automatic redirect(input pc_word_t target);
        branch_taken  <= 1'b1;
        branch_target <= target;
        @(posedge clk);
        branch_taken  <= 1'b0;
    endtask

    // Drive decode ready and branches until enough transfers are seen
    task automatic run_stream(input int count, input bit random_ready, input bit random_branch);
        int goal;
        goal = accepted + count;
        while (accepted < goal) begin
            stim_rng = lcg_next(stim_rng);
            ready <= random_ready ? stim_rng[31] : 1'b1;
            if (random_branch && stim_rng[27:24] == 4'd0) begin
                stim_rng = lcg_next(stim_rng);
                branch_taken  <= 1'b1;
                branch_target <= random_target(stim_rng);
            end else begin
                branch_taken <= 1'b0;
            end
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_on_error($sformatf("timeout after %0d cycles, fetch stream stopped", cycles));
        end
    end

    // Page walker, one request at a time, 1 to 8 cycles
    always @(posedge clk) begin
        if (!walker_on) begin
            fill_valid <= 1'b0;
        end else if (fill_valid) begin
            // Entry written on this edge
            check_miss_request();
            fill_valid <= 1'b0;
            walk_busy = 1'b0;
        end else if (walk_busy) begin
            check_miss_request();
            walk_count = walk_count - 1;
            if (walk_count == 0) begin
                fill_valid <= 1'b1;
                fill_vpn   <= walk_vpn;
                fill_ppn   <= map_ppn(walk_vpn);
                page_filled[walk_vpn] = 1'b1;
            end
        end else if (miss_valid) begin
            // Visited pages never collide, so a refilled page must hit
            assert (!page_filled.exists(miss_vpn)) else
                stop_on_error($sformatf("mismatch at time %0t: new miss for filled page %h",
                                        $time, miss_vpn));
            walk_rng   = lcg_next(walk_rng);
            walk_count = 1 + int'(walk_rng[30:28]);
            walk_vpn   = miss_vpn;
            walk_busy  = 1'b1;
            // A redirect on this edge moves the PC away from the request
            walk_track = !branch_taken;
        end
    end

    // Compare every transfer with the expected stream
    always @(posedge clk) begin
        if (rst_n) begin
            if (held) begin
                assert (out_valid && out_pc_word == held_pc && out_instr == held_instr) else
                    stop_on_error($sformatf("mismatch at time %0t: stalled output at pc %h moved",
                                            $time, held_pc));
            end
            if (out_valid && ready) begin
                assert (out_pc_word == expect_pc) else
                    stop_on_error($sformatf("mismatch at time %0t: pc %h, expected %h",
                                            $time, out_pc_word, expect_pc));
                assert (out_instr == expected_instr(expect_pc)) else
                    stop_on_error($sformatf("mismatch at time %0t: instr %h at pc %h, expected %h",
                                            $time, out_instr, expect_pc,
                                            expected_instr(expect_pc)));
                assert (page_filled.exists(out_pc_word[PC_WORD_BITS-1:PAGE_OFF_BITS])) else
                    stop_on_error($sformatf("mismatch at time %0t: pc %h from an unmapped page",
                                            $time, out_pc_word));
                expect_pc = out_pc_word + pc_word_t'(1);
                accepted <= accepted + 1;
            end
            held       = out_valid && !ready && !branch_taken;
            held_pc    = out_pc_word;
            held_instr = out_instr;
            // Redirect wins over the sequential successor
            if (branch_taken) begin
                expect_pc = branch_target;
            end
        end
    end

    initial begin
        rst_n         <= 1'b0;
        branch_taken  <= 1'b0;
        branch_target <= '0;
        load_en       <= 1'b0;
        load_addr     <= '0;
        load_data     <= '0;
        ready         <= 1'b1;
        walker_on     <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!out_valid && !miss_valid) else
            stop_on_error($sformatf("mismatch at time %0t: o_valid or o_miss_valid set after reset",
                                    $time));

        // Program load, front end waits on its first miss meanwhile
        for (int i = 0; i < IMEM_WORDS; i++) begin
            load_en   <= 1'b1;
            load_addr <= IMEM_ADDR_BITS'(i);
            load_data <= load_pattern(IMEM_ADDR_BITS'(i));
            @(posedge clk);
        end
        load_en   <= 1'b0;
        walker_on <= 1'b1;

        // First fetch from the reset PC
        run_stream(1, 1'b0, 1'b0);

        // Sequential runs that cross pages 3 to 6
        for (int r = 0; r < RUNS; r++) begin
            redirect(pc_word_t'((r + 3) * PAGE_WORDS - 25));
            run_stream(RUN_FETCHES, 1'b0, 1'b0);
        end

        // Random back-pressure, then back-pressure with branches
        run_stream(STALL_FETCHES, 1'b1, 1'b0);
        run_stream(BRANCH_FETCHES, 1'b1, 1'b1);
        ready        <= 1'b1;
        branch_taken <= 1'b0;
        repeat (4) @(posedge clk);

        $display("Result: PASSED");
        $finish;
    end

endmodule : fetch_tb

`default_nettype wire

//--- hw/fetch_frontend.sv
// Fetch front end top level joining F1, the ITLB, F2 and the instruction memory
`default_nettype none
`timescale 1ns/100ps

module fetch_frontend #(
    parameter int ITLB_INDEX_BITS = 3,
    parameter int IMEM_ADDR_BITS  = 10
) (
    // Clock and reset
    input  wire                         i_clk,
    input  wire                         i_rst_n,

    // Redirect pulse
    input  wire                         i_branch_taken,
    input  wire fetch_pkg::pc_word_t    i_branch_target,

    // Page walker
    output fetch_pkg::vpn_t             o_miss_vpn,
    output logic                        o_miss_valid,
    input  wire                         i_fill_valid,
    input  wire fetch_pkg::vpn_t        i_fill_vpn,
    input  wire fetch_pkg::ppn_t        i_fill_ppn,

    // Program load
    input  wire                         i_load_en,
    input  wire [IMEM_ADDR_BITS-1:0]    i_load_addr,
    input  wire fetch_pkg::word_t       i_load_data,

    // To decode
    output logic                        o_valid,
    output fetch_pkg::pc_word_t         o_pc_word,
    output fetch_pkg::word_t            o_instr,
    input  wire                         i_ready
);

    import fetch_pkg::*;

    // Stall is output valid held by decode
    logic        stall;

    // ITLB lookup
    pc_word_t    lookup_pc_word;
    logic        tlb_hit;
    paddr_word_t tlb_paddr_word;

    // F1 to F2 and memory
    logic        f1_valid;
    pc_word_t    f1_pc_word;
    paddr_word_t f1_paddr_word;

    // Memory read
    logic        read_en;
    word_t       read_data;

    fetch_stage_f1 u_f1 (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_branch_taken   (i_branch_taken),
        .i_branch_target  (i_branch_target),
        .i_stall          (stall),
        .o_lookup_pc_word (lookup_pc_word),
        .i_tlb_hit        (tlb_hit),
        .i_tlb_paddr_word (tlb_paddr_word),
        .o_f1_valid       (f1_valid),
        .o_f1_pc_word     (f1_pc_word),
        .o_f1_paddr_word  (f1_paddr_word)
    );

    fetch_itlb #(
        .ITLB_INDEX_BITS (ITLB_INDEX_BITS)
    ) u_itlb (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_lookup_pc_word (lookup_pc_word),
        .o_hit            (tlb_hit),
        .o_paddr_word     (tlb_paddr_word),
        .o_miss_valid     (o_miss_valid),
        .o_miss_vpn       (o_miss_vpn),
        .i_fill_valid     (i_fill_valid),
        .i_fill_vpn       (i_fill_vpn),
        .i_fill_ppn       (i_fill_ppn)
    );

    // Memory indexed by the low physical word bits
    fetch_imem #(
        .IMEM_ADDR_BITS (IMEM_ADDR_BITS)
    ) u_imem (
        .i_clk       (i_clk),
        .i_read_en   (read_en),
        .i_read_addr (f1_paddr_word[IMEM_ADDR_BITS-1:0]),
        .o_read_data (read_data),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data)
    );

    // Branch pulse doubles as the flush
    fetch_stage_f2 u_f2 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_flush      (i_branch_taken),
        .i_f1_valid   (f1_valid),
        .i_f1_pc_word (f1_pc_word),
        .o_read_en    (read_en),
        .i_read_data  (read_data),
        .o_valid      (o_valid),
        .o_pc_word    (o_pc_word),
        .o_instr      (o_instr),
        .i_ready      (i_ready),
        .o_stall      (stall)
    );

endmodule : fetch_frontend

`default_nettype wire

//--- hw/fetch_stage_f2.sv
// Second fetch stage that pairs the PC with the memory read and drives the decode handshake
`default_nettype none
`timescale 1ns/100ps

module fetch_stage_f2 (
    // Clock and reset
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_flush,

    // From F1
    input  wire                         i_f1_valid,
    input  wire fetch_pkg::pc_word_t    i_f1_pc_word,

    // Instruction memory
    output logic                        o_read_en,
    input  wire fetch_pkg::word_t       i_read_data,

    // To decode
    output logic                        o_valid,
    output fetch_pkg::pc_word_t         o_pc_word,
    output fetch_pkg::word_t            o_instr,
    input  wire                         i_ready,

    // Freeze for PC, F1 and memory
    output logic                        o_stall
);

    // Held output that decode has not taken
    assign o_stall   = o_valid && !i_ready;

    // Read only for a live fetch that can advance
    assign o_read_en = i_f1_valid && !o_stall;

    // Data arrives in step with the PC flop
    assign o_instr   = i_read_data;

    // Output valid
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;
        end else if (!o_stall) begin
            o_valid <= i_f1_valid;
        end
    end

    // PC lines up with the registered read
    always_ff @(posedge i_clk) begin
        if (!o_stall) begin
            o_pc_word <= i_f1_pc_word;
        end
    end

endmodule : fetch_stage_f2

`default_nettype wire

//--- hw/fetch_imem.sv
// Instruction RAM with a registered read port for fetch and a write port for program loading
`default_nettype none
`timescale 1ns/100ps

module fetch_imem #(
    parameter int IMEM_ADDR_BITS = 10
) (
    input  wire                         i_clk,

    // Fetch read port
    input  wire                         i_read_en,
    input  wire [IMEM_ADDR_BITS-1:0]    i_read_addr,
    output fetch_pkg::word_t            o_read_data,

    // Program load port
    input  wire                         i_load_en,
    input  wire [IMEM_ADDR_BITS-1:0]    i_load_addr,
    input  wire fetch_pkg::word_t       i_load_data
);

    import fetch_pkg::*;

    localparam int DEPTH = 2 ** IMEM_ADDR_BITS;

    word_t mem [DEPTH];

    // Program load
    always_ff @(posedge i_clk) begin
        if (i_load_en) begin
            mem[i_load_addr] <= i_load_data;
        end
    end

    // Registered read
    always_ff @(posedge i_clk) begin
        if (i_read_en) begin
            // Output holds while the enable is low
            o_read_data <= mem[i_read_addr];
        end
    end

endmodule : fetch_imem

`default_nettype wire

//--- hw/fetch_itlb.sv
// Direct-mapped instruction TLB with a combinational lookup, a walker miss request and a fill port
`default_nettype none
`timescale 1ns/100ps

module fetch_itlb #(
    parameter int ITLB_INDEX_BITS = 3
) (
    // Clock and reset
    input  wire                         i_clk,
    input  wire                         i_rst_n,

    // Lookup from F1
    input  wire fetch_pkg::pc_word_t    i_lookup_pc_word,
    output logic                        o_hit,
    output fetch_pkg::paddr_word_t      o_paddr_word,

    // Request to the page walker
    output logic                        o_miss_valid,
    output fetch_pkg::vpn_t             o_miss_vpn,

    // Walker answer
    input  wire                         i_fill_valid,
    input  wire fetch_pkg::vpn_t        i_fill_vpn,
    input  wire fetch_pkg::ppn_t        i_fill_ppn
);

    import fetch_pkg::*;

    localparam int ENTRIES  = 2 ** ITLB_INDEX_BITS;
    localparam int TAG_BITS = VPN_BITS - ITLB_INDEX_BITS;

    typedef logic [ITLB_INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]        tag_t;

    // Entry storage
    logic [ENTRIES-1:0] entry_valid;
    tag_t               entry_tag [ENTRIES];
    ppn_t               entry_ppn [ENTRIES];

    vpn_t      lookup_vpn;
    page_off_t lookup_off;
    index_t    lookup_index;
    tag_t      lookup_tag;
    index_t    fill_index;
    tag_t      fill_tag;
    logic      walk_en;

    // Split the fetch PC
    assign lookup_vpn   = i_lookup_pc_word[PC_WORD_BITS-1:PAGE_OFF_BITS];
    assign lookup_off   = i_lookup_pc_word[PAGE_OFF_BITS-1:0];
    assign lookup_index = lookup_vpn[ITLB_INDEX_BITS-1:0];
    assign lookup_tag   = lookup_vpn[VPN_BITS-1:ITLB_INDEX_BITS];

    assign fill_index   = i_fill_vpn[ITLB_INDEX_BITS-1:0];
    assign fill_tag     = i_fill_vpn[VPN_BITS-1:ITLB_INDEX_BITS];

    // Lookup and translation
    assign o_hit        = entry_valid[lookup_index] && (entry_tag[lookup_index] == lookup_tag);
    assign o_paddr_word = {entry_ppn[lookup_index], lookup_off};

    // Request stays up while the PC misses
    assign o_miss_valid = walk_en && !o_hit;
    assign o_miss_vpn   = lookup_vpn;

    // Valid bits, and requests start one cycle out of reset
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            entry_valid <= '0;
            walk_en     <= 1'b0;
        end else begin
            walk_en <= 1'b1;
            if (i_fill_valid) begin
                entry_valid[fill_index] <= 1'b1;
            end
        end
    end

    // Fill overwrites whatever shares the index
    always_ff @(posedge i_clk) begin
        if (i_fill_valid) begin
            entry_tag[fill_index] <= fill_tag;
            entry_ppn[fill_index] <= i_fill_ppn;
        end
    end

endmodule : fetch_itlb

`default_nettype wire

//--- hw/fetch_stage_f1.sv
// First fetch stage that owns the PC, applies redirects and flops the translated fetch for F2
`default_nettype none
`timescale 1ns/100ps

module fetch_stage_f1 (
    // Clock and reset
    input  wire                         i_clk,
    input  wire                         i_rst_n,

    // Redirect, also used as the flush
    input  wire                         i_branch_taken,
    input  wire fetch_pkg::pc_word_t    i_branch_target,

    // Back-pressure from F2
    input  wire                         i_stall,

    // ITLB lookup of the current PC
    output fetch_pkg::pc_word_t         o_lookup_pc_word,
    input  wire                         i_tlb_hit,
    input  wire fetch_pkg::paddr_word_t i_tlb_paddr_word,

    // To F2 and the instruction memory
    output logic                        o_f1_valid,
    output fetch_pkg::pc_word_t         o_f1_pc_word,
    output fetch_pkg::paddr_word_t      o_f1_paddr_word
);

    import fetch_pkg::*;

    pc_word_t pc_word;
    pc_word_t next_seq_pc_word;
    pc_word_t next_pc_word;

    assign next_seq_pc_word = pc_word + pc_word_t'(1);

    // Next PC selection
    always_comb begin
        if (i_branch_taken) begin
            next_pc_word = i_branch_target;
        end else if (i_tlb_hit) begin
            next_pc_word = next_seq_pc_word;
        end else begin
            // Wait here for the walker fill
            next_pc_word = pc_word;
        end
    end

    // A branch pulse has no handshake, so it loads even under stall
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_word <= RESET_PC_WORD;
        end else if (i_branch_taken || !i_stall) begin
            pc_word <= next_pc_word;
        end
    end

    // Translation works on the registered PC
    assign o_lookup_pc_word = pc_word;

    // F1/F2 valid
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_f1_valid <= 1'b0;
        end else if (i_branch_taken) begin
            // Drop the wrong-path fetch
            o_f1_valid <= 1'b0;
        end else if (!i_stall) begin
            // Miss sends a bubble
            o_f1_valid <= i_tlb_hit;
        end
    end

    // F1/F2 payload, qualified by valid
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_f1_pc_word    <= pc_word;
            o_f1_paddr_word <= i_tlb_paddr_word;
        end
    end

endmodule : fetch_stage_f1

`default_nettype wire

//--- hw/fetch_pkg.sv
// Shared widths, page geometry and reset PC for the fetch front end, imported by each fetch module
`default_nettype none

package fetch_pkg;

    // Datapath and address widths
    localparam int WORD_BITS     = 32;
    localparam int PC_WORD_BITS  = 30;
    localparam int PADDR_BITS    = 30;

    // 4 KiB pages hold 1024 words
    localparam int PAGE_OFF_BITS = 10;
    localparam int VPN_BITS      = PC_WORD_BITS - PAGE_OFF_BITS;
    localparam int PPN_BITS      = PADDR_BITS - PAGE_OFF_BITS;

    typedef logic [WORD_BITS-1:0]     word_t;
    typedef logic [PC_WORD_BITS-1:0]  pc_word_t;
    typedef logic [VPN_BITS-1:0]      vpn_t;
    typedef logic [PPN_BITS-1:0]      ppn_t;
    typedef logic [PAGE_OFF_BITS-1:0] page_off_t;

    // Physical word address is ppn then page offset
    typedef logic [PADDR_BITS-1:0]    paddr_word_t;

    // Byte address 0x0000_1000 as a word index
    localparam pc_word_t RESET_PC_WORD = pc_word_t'(32'h0000_1000 >> 2);

endpackage : fetch_pkg

`default_nettype wire
